/* src/nes_host_pkg.sv */
/* NES host shared definitions
   Widths, constants and request structs used across the host blocks */
package nes_host_pkg;

	localparam int MEM_ADDR_W   = 16;
	localparam int SAVE_ADDR_W  = 13;
	localparam logic [MEM_ADDR_W-1:0] SAVE_BASE = 16'hE000; // Start of save-RAM window
	localparam int SECTOR_BYTES = 512;
	localparam int LBA_W        = 12;
	localparam logic [7:0] DL_RESET_CYCLES = 8'd255;
	localparam logic [1:0] LOAD_PHASE      = 2'd3;     // Memory phase for loader commits
	localparam int FLAGS_W      = 32;

	// Host order, right in bit 0
	typedef struct packed {
		logic start;
		logic select;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_t;

	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic                  rd;     // One-cycle strobe
		logic                  wr;     // One-cycle strobe
		logic [7:0]            wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic [7:0]            data;
		logic                  write;
	} mem_wr_t;

	// Offset is relative to SAVE_BASE
	typedef struct packed {
		logic [SAVE_ADDR_W-1:0] offset;
		logic                   oe;
		logic                   we;
		logic [7:0]             wdata;
	} backup_req_t;

	typedef struct packed {
		logic [LBA_W-1:0] lba;
		logic             rd;
		logic             wr;
	} sd_req_t;

endpackage

/* src/joypad_port.sv */
/* Joypad port
   Latches both controller bytes in console order and serializes them */
`timescale 1ns/1ns

module joypad_port (
	input  logic               clk,
	input  logic               reset_nes,
	input  nes_host_pkg::pad_t joy_a,
	input  nes_host_pkg::pad_t joy_b,
	input  logic               joy_swap,
	input  logic               joypad_strobe,
	input  logic [1:0]         joypad_clock,
	output logic [1:0]         joypad_data
);
	import nes_host_pkg::*;

	pad_t       pad_sel [2];
	logic [7:0] shreg [2];   // One shift register per port
	logic [1:0] clock_d;

	// Console order: A, B, select, start, up, down, left, right from bit 0
	function automatic logic [7:0] to_console(pad_t p);
		return {p.right, p.left, p.down, p.up, p.start, p.select, p.b, p.a};
	endfunction

	assign pad_sel[0] = joy_swap ? joy_b : joy_a;
	assign pad_sel[1] = joy_swap ? joy_a : joy_b;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shreg[0] <= 8'd0;
			shreg[1] <= 8'd0;
			clock_d  <= 2'b00;
		end else begin
			for (int n = 0; n < 2; n++) begin
				if (joypad_strobe)
					shreg[n] <= to_console(pad_sel[n]);
				// Falling clock edge wins over strobe
				if (clock_d[n] && !joypad_clock[n])
					shreg[n] <= {1'b0, shreg[n][7:1]};
			end
			clock_d <= joypad_clock;
		end
	end

	assign joypad_data = {shreg[1][0], shreg[0][0]};

endmodule

/* src/boot_reset.sv */
/* Console reset generator
   Holds the console in reset at power-up, after downloads and on loader failure */
`timescale 1ns/1ns

module boot_reset (
	input  logic clk,
	input  logic reset_nes,
	input  logic downloading,
	input  logic loader_busy,
	input  logic loader_fail,
	output logic console_reset
);
	import nes_host_pkg::*;

	logic       init_hold;   // Cleared by the first download
	logic [7:0] dl_cnt;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			init_hold <= 1'b1;
			dl_cnt    <= 8'd0;
		end else begin
			if (downloading)
				init_hold <= 1'b0;
			if (downloading)
				dl_cnt <= DL_RESET_CYCLES;   // Reload while data streams in
			else if (!loader_busy && dl_cnt != 8'd0)
				dl_cnt <= dl_cnt - 8'd1;
		end
	end

	assign console_reset = init_hold || (dl_cnt != 8'd0) || loader_fail;

	// Post-download hold may only start from a download
	a_cnt_start: assert property (@(posedge clk) disable iff (reset_nes)
		$rose(dl_cnt != 8'd0) |-> $past(downloading));

endmodule

/* src/loader_capture.sv */
/* Loader write capture
   Holds one loader write until memory phase 3 and latches the mapper flags */
`timescale 1ns/1ns

module loader_capture (
	input  logic                               clk,
	input  logic                               reset_nes,
	input  logic                               downloading,
	input  logic                               loader_busy,
	input  logic                               loader_done,
	input  logic [nes_host_pkg::FLAGS_W-1:0]   loader_flags,
	input  nes_host_pkg::mem_wr_t              loader_wr,
	input  logic [1:0]                         nes_phase,
	output nes_host_pkg::mem_wr_t              commit_wr,
	output logic                               load_owns_bus,
	output logic [nes_host_pkg::FLAGS_W-1:0]   mapper_flags
);
	import nes_host_pkg::*;

	logic                  pending;
	logic [MEM_ADDR_W-1:0] slot_addr;
	logic [7:0]            slot_data;
	logic                  commit;

	assign commit = pending && (nes_phase == LOAD_PHASE);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending      <= 1'b0;
			mapper_flags <= '0;
		end else begin
			if (loader_wr.write)
				pending <= 1'b1;   // New write replaces the one committing now
			else if (commit)
				pending <= 1'b0;
			if (loader_done)
				mapper_flags <= loader_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (loader_wr.write) begin
			slot_addr <= loader_wr.addr;
			slot_data <= loader_wr.data;
		end
	end

	assign commit_wr = '{addr: slot_addr, data: slot_data, write: commit};
	assign load_owns_bus = downloading || loader_busy;   // CPU locked out of memory

	// Loader must not overrun the single slot
	a_no_overrun: assert property (@(posedge clk) disable iff (reset_nes)
		loader_wr.write |-> !pending || commit);

endmodule

/* src/save_backup.sv */
/* Save-RAM backup sequencer
   Moves SD sectors between the SD buffer and the save-RAM window */
`timescale 1ns/1ns

module save_backup (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      downloading,
	input  logic                      img_mounted,
	input  logic [31:0]               img_size,
	input  logic                      bk_load,
	input  logic                      bk_save,
	input  logic                      sd_ack,
	input  logic                      sd_buff_wr,
	input  logic                      sd_buff_rd,
	input  logic [7:0]                sd_buff_dout,
	input  logic                      bk_ack,
	input  logic [7:0]                bk_rdata,
	output nes_host_pkg::sd_req_t     sd,
	output logic [7:0]                sd_buff_din,
	output nes_host_pkg::backup_req_t bk_req,
	output logic                      bk_ena
);
	import nes_host_pkg::*;

	logic                   mounted_d;
	logic                   downloading_d;
	logic                   bk_load_d;
	logic                   bk_save_d;
	logic                   sd_ack_d;
	logic                   busy;        // 0 idle, 1 sector transfer
	logic                   loading;     // Direction of the current run
	logic [LBA_W-1:0]       lba;
	logic                   sd_rd;
	logic                   sd_wr;
	logic [LBA_W-1:0]       sec_count;
	logic [SAVE_ADDR_W-1:0] offset;
	logic                   req_oe;
	logic                   req_we;
	logic [7:0]             req_wdata;
	logic                   mount_rise;
	logic                   load_rise;
	logic                   save_rise;
	logic                   seq_start;

	assign mount_rise = img_mounted && !mounted_d;
	assign load_rise  = bk_load && !bk_load_d;
	assign save_rise  = bk_save && !bk_save_d;
	assign seq_start  = !busy && bk_ena && (load_rise || save_rise);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mounted_d     <= 1'b0;
			downloading_d <= 1'b0;
			bk_load_d     <= 1'b0;
			bk_save_d     <= 1'b0;
			sd_ack_d      <= 1'b0;
			bk_ena        <= 1'b0;
			busy          <= 1'b0;
			loading       <= 1'b0;
			lba           <= '0;
			sd_rd         <= 1'b0;
			sd_wr         <= 1'b0;
			req_oe        <= 1'b0;
			req_we        <= 1'b0;
		end else begin
			mounted_d     <= img_mounted;
			downloading_d <= downloading;
			bk_load_d     <= bk_load;
			bk_save_d     <= bk_save;
			sd_ack_d      <= sd_ack;

			if (mount_rise)
				bk_ena <= |img_size;
			if (downloading && !downloading_d)
				bk_ena <= 1'b0;   // New game, old save no longer valid

			if (sd_ack && !sd_ack_d) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (seq_start) begin
				busy    <= 1'b1;
				loading <= load_rise;
				lba     <= '0;
				sd_rd   <= load_rise;
				sd_wr   <= !load_rise;
			end else if (busy && sd_ack_d && !sd_ack) begin
				// Host finished a sector
				if (lba + LBA_W'(1) == sec_count) begin
					busy    <= 1'b0;
					loading <= 1'b0;
				end else begin
					lba   <= lba + LBA_W'(1);
					sd_rd <= loading;
					sd_wr <= !loading;
				end
			end

			if (bk_ack) begin
				req_oe <= 1'b0;
				req_we <= 1'b0;
			end
			if (sd_buff_wr)
				req_we <= 1'b1;
			if (sd_buff_rd)
				req_oe <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mount_rise)
			sec_count <= LBA_W'(img_size >> $clog2(SECTOR_BYTES));
		if (seq_start)
			offset <= '1;   // First strobe wraps to 0
		if (sd_buff_wr || sd_buff_rd)
			offset <= offset + SAVE_ADDR_W'(1);
		if (sd_buff_wr)
			req_wdata <= sd_buff_dout;
		if (bk_ack && req_oe)
			sd_buff_din <= bk_rdata;
	end

	assign sd     = '{lba: lba, rd: sd_rd, wr: sd_wr};
	assign bk_req = '{offset: offset, oe: req_oe, we: req_we, wdata: req_wdata};

	// SD host must wait for the previous byte to reach memory
	a_strobe_spacing: assert property (@(posedge clk) disable iff (reset_nes)
		(sd_buff_wr || sd_buff_rd) |-> !(req_oe || req_we) || bk_ack);

endmodule

/* src/cart_mem_arbiter.sv */
/* Cartridge memory with fixed-priority arbiter
   Serves loader commits, CPU strobes and backup requests one access per cycle */
`timescale 1ns/1ns

module cart_mem_arbiter (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  nes_host_pkg::cpu_bus_t    cpu,
	input  logic                      load_owns_bus,
	input  nes_host_pkg::mem_wr_t     commit_wr,
	input  nes_host_pkg::backup_req_t bk_req,
	output logic [7:0]                cpu_rdata,
	output logic                      bk_ack,
	output logic [7:0]                bk_rdata
);
	import nes_host_pkg::*;

	logic [7:0]            mem [2**MEM_ADDR_W];
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [7:0]            mem_wdata;
	logic                  mem_we;
	logic                  mem_re;
	logic                  grant_ld;
	logic                  grant_cpu;
	logic                  grant_bk;
	logic [7:0]            rd_q;

	always_comb begin
		grant_ld  = commit_wr.write;
		grant_cpu = !grant_ld && !load_owns_bus && (cpu.rd || cpu.wr);
		// Request still high during its ack cycle, skip it then
		grant_bk  = !grant_ld && !grant_cpu && !bk_ack && (bk_req.oe || bk_req.we);

		mem_addr  = SAVE_BASE + MEM_ADDR_W'(bk_req.offset);
		mem_wdata = bk_req.wdata;
		mem_we    = grant_bk && bk_req.we;
		mem_re    = grant_bk && bk_req.oe;
		if (grant_ld) begin
			mem_addr  = commit_wr.addr;
			mem_wdata = commit_wr.data;
			mem_we    = 1'b1;
			mem_re    = 1'b0;
		end else if (grant_cpu) begin
			mem_addr  = cpu.addr;
			mem_wdata = cpu.wdata;
			mem_we    = cpu.wr;
			mem_re    = cpu.rd;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		if (mem_re)
			rd_q <= mem[mem_addr];   // Shared read register
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			bk_ack <= 1'b0;
		else
			bk_ack <= grant_bk;
	end

	assign cpu_rdata = rd_q;
	assign bk_rdata  = rd_q;

	a_one_grant: assert property (@(posedge clk) disable iff (reset_nes)
		$onehot0({grant_ld, grant_cpu, grant_bk}));

endmodule

/* src/nes_host_top.sv */
/* NES host top level
   Joypads, console reset, loader capture, save backup and cartridge memory */
`timescale 1ns/1ns

module nes_host_top (
	input  logic                             clk,
	input  logic                             reset_nes,
	input  nes_host_pkg::cpu_bus_t           cpu,
	input  logic [1:0]                       nes_phase,
	input  nes_host_pkg::pad_t               joy_a,
	input  nes_host_pkg::pad_t               joy_b,
	input  logic                             joy_swap,
	input  logic                             joypad_strobe,
	input  logic [1:0]                       joypad_clock,
	input  logic                             downloading,
	input  logic                             loader_busy,
	input  logic                             loader_done,
	input  logic                             loader_fail,
	input  logic [nes_host_pkg::FLAGS_W-1:0] loader_flags,
	input  nes_host_pkg::mem_wr_t            loader_wr,
	input  logic                             img_mounted,
	input  logic [31:0]                      img_size,
	input  logic                             bk_load,
	input  logic                             bk_save,
	input  logic                             sd_ack,
	input  logic                             sd_buff_wr,
	input  logic                             sd_buff_rd,
	input  logic [7:0]                       sd_buff_dout,
	output logic [7:0]                       cpu_rdata,
	output logic [1:0]                       joypad_data,
	output logic                             console_reset,
	output logic [nes_host_pkg::FLAGS_W-1:0] mapper_flags,
	output nes_host_pkg::sd_req_t            sd,
	output logic [7:0]                       sd_buff_din,
	output logic                             bk_ena
);
	import nes_host_pkg::*;

	mem_wr_t     commit_wr;
	logic        load_owns_bus;
	backup_req_t bk_req;
	logic        bk_ack;
	logic [7:0]  bk_rdata;

	joypad_port u_joypad (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_swap      (joy_swap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

	boot_reset u_boot_reset (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.downloading   (downloading),
		.loader_busy   (loader_busy),
		.loader_fail   (loader_fail),
		.console_reset (console_reset)
	);

	loader_capture u_loader (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.downloading   (downloading),
		.loader_busy   (loader_busy),
		.loader_done   (loader_done),
		.loader_flags  (loader_flags),
		.loader_wr     (loader_wr),
		.nes_phase     (nes_phase),
		.commit_wr     (commit_wr),
		.load_owns_bus (load_owns_bus),
		.mapper_flags  (mapper_flags)
	);

	save_backup u_backup (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.downloading  (downloading),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.sd_ack       (sd_ack),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_rd   (sd_buff_rd),
		.sd_buff_dout (sd_buff_dout),
		.bk_ack       (bk_ack),
		.bk_rdata     (bk_rdata),
		.sd           (sd),
		.sd_buff_din  (sd_buff_din),
		.bk_req       (bk_req),
		.bk_ena       (bk_ena)
	);

	cart_mem_arbiter u_cart_mem (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.cpu           (cpu),
		.load_owns_bus (load_owns_bus),
		.commit_wr     (commit_wr),
		.bk_req        (bk_req),
		.cpu_rdata     (cpu_rdata),
		.bk_ack        (bk_ack),
		.bk_rdata      (bk_rdata)
	);

endmodule

/* tb/nes_host_model.svh */
/* NES host reference model
   Model memory, pad reordering, sector image and typed compare tasks */
`ifndef NES_HOST_MODEL_SVH
`define NES_HOST_MODEL_SVH

logic [7:0] model_mem [0:2**MEM_ADDR_W-1];
logic [7:0] sector_img [0:2*SECTOR_BYTES-1];   // Bytes the SD host supplied on load

// Serialized console order back to host order
function automatic pad_t from_console(logic [7:0] c);
	pad_t p;
	p.a      = c[0];
	p.b      = c[1];
	p.select = c[2];
	p.start  = c[3];
	p.up     = c[4];
	p.down   = c[5];
	p.left   = c[6];
	p.right  = c[7];
	return p;
endfunction

task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("Error %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_pad(string name, pad_t exp, pad_t act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("Error %s: expected %b, actual %b", name, exp, act);
	end
endtask

task automatic check_sd(string name, sd_req_t exp, sd_req_t act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("Error %s: expected lba %0d rd %b wr %b, actual lba %0d rd %b wr %b",
			name, exp.lba, exp.rd, exp.wr, act.lba, act.rd, act.wr);
	end
endtask

task automatic check_flags(string name, logic [FLAGS_W-1:0] exp, logic [FLAGS_W-1:0] act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("Error %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_level(string name, logic exp, logic act);
	check_count++;
	if (act !== exp) begin
		error_count++;
		$display("Error %s: expected %b, actual %b", name, exp, act);
	end
endtask

`endif

/* tb/tb_nes_host.sv */
/* NES host testbench
   Random stimulus against a reference model, with the testbench acting as SD host */
`timescale 1ns/1ns

module tb_nes_host;
	import nes_host_pkg::*;

	logic                 clk;
	logic                 reset_nes;
	cpu_bus_t             cpu;
	logic [1:0]           nes_phase;
	pad_t                 joy_a;
	pad_t                 joy_b;
	logic                 joy_swap;
	logic                 joypad_strobe;
	logic [1:0]           joypad_clock;
	logic                 downloading;
	logic                 loader_busy;
	logic                 loader_done;
	logic                 loader_fail;
	logic [FLAGS_W-1:0]   loader_flags;
	mem_wr_t              loader_wr;
	logic                 img_mounted;
	logic [31:0]          img_size;
	logic                 bk_load;
	logic                 bk_save;
	logic                 sd_ack;
	logic                 sd_buff_wr;
	logic                 sd_buff_rd;
	logic [7:0]           sd_buff_dout;
	logic [7:0]           cpu_rdata;
	logic [1:0]           joypad_data;
	logic                 console_reset;
	logic [FLAGS_W-1:0]   mapper_flags;
	sd_req_t              sd;
	logic [7:0]           sd_buff_din;
	logic                 bk_ena;

	logic [31:0]          rng_state;
	logic [15:0]          written_q [$];   // Addresses the model knows
	int                   check_count;
	int                   error_count;
	int                   errors_at_start;
	int                   tests_run;
	int                   tests_failed;

	`include "nes_host_model.svh"

	nes_host_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Console memory phase, free running
	initial begin
		nes_phase = 2'd0;
		forever begin
			@(negedge clk);
			nes_phase = nes_phase + 2'd1;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic finish_test(string name);
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	task automatic wait_sd_request(int limit);
		int n;
		n = 0;
		while (!(sd.rd || sd.wr)) begin
			if (n == limit)
				abort_run("Timeout waiting for an SD sector request");
			@(negedge clk);
			n++;
		end
	endtask

	task automatic cpu_write(logic [15:0] addr, logic [7:0] data);
		cpu = '{addr: addr, rd: 1'b0, wr: 1'b1, wdata: data};
		@(negedge clk);
		cpu.wr = 1'b0;
		model_mem[addr] = data;
		written_q.push_back(addr);
	endtask

	// Data is taken one cycle after the strobe
	task automatic cpu_read(logic [15:0] addr, output logic [7:0] data);
		cpu = '{addr: addr, rd: 1'b1, wr: 1'b0, wdata: 8'h00};
		@(negedge clk);
		cpu.rd = 1'b0;
		data = cpu_rdata;
	endtask

	task automatic test_joypads();
		logic [31:0] r;
		logic [7:0]  got0;
		logic [7:0]  got1;
		for (int round = 0; round < 4; round++) begin
			r = next_rand();
			joy_a = pad_t'(r[7:0]);
			joy_b = pad_t'(r[15:8]);
			joy_swap = r[16];
			joypad_strobe = 1'b1;
			@(negedge clk);
			joypad_strobe = 1'b0;
			for (int k = 0; k < 8; k++) begin
				got0[k] = joypad_data[0];
				got1[k] = joypad_data[1];
				joypad_clock = 2'b11;
				@(negedge clk);
				joypad_clock = 2'b00;   // Falling edge shifts both ports
				@(negedge clk);
			end
			check_pad("joypad port 0", joy_swap ? joy_b : joy_a, from_console(got0));
			check_pad("joypad port 1", joy_swap ? joy_a : joy_b, from_console(got1));
		end
		finish_test("joypads");
	endtask

	task automatic test_console_reset();
		int n;
		check_level("console_reset before download", 1'b1, console_reset);
		downloading = 1'b1;
		loader_busy = 1'b1;
		repeat (4) @(negedge clk);
		downloading = 1'b0;
		repeat (40) @(negedge clk);   // Busy long enough to expose an early countdown
		check_level("console_reset while loader busy", 1'b1, console_reset);
		loader_busy = 1'b0;
		n = 0;
		while (console_reset) begin
			if (n == 400)
				abort_run("Timeout waiting for console_reset to fall after a download");
			@(negedge clk);
			n++;
		end
		check_count++;
		if (n < 250 || n > 260) begin
			error_count++;
			$display("Error console_reset hold: expected 250 to 260 cycles, actual %0d", n);
		end
		loader_fail = 1'b1;
		@(negedge clk);
		check_level("console_reset on loader failure", 1'b1, console_reset);
		loader_fail = 1'b0;
		@(negedge clk);
		check_level("console_reset after loader failure", 1'b0, console_reset);
		finish_test("console reset");
	endtask

	task automatic test_loader();
		logic [31:0] r;
		logic [31:0] flags;
		logic [7:0]  data;
		downloading = 1'b1;
		loader_busy = 1'b1;
		@(negedge clk);
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			loader_wr = '{addr: r[15:0], data: r[23:16], write: 1'b1};
			model_mem[r[15:0]] = r[23:16];
			written_q.push_back(r[15:0]);
			@(negedge clk);
			loader_wr.write = 1'b0;
			repeat (5) @(negedge clk);   // Commit lands in the next phase 3
		end
		flags = next_rand();
		loader_flags = flags;
		loader_done = 1'b1;
		@(negedge clk);
		loader_done = 1'b0;
		check_flags("mapper_flags", flags, mapper_flags);
		downloading = 1'b0;
		loader_busy = 1'b0;
		@(negedge clk);
		foreach (written_q[i]) begin
			cpu_read(written_q[i], data);
			check_byte("loader readback", model_mem[written_q[i]], data);
		end
		finish_test("loader");
	endtask

	task automatic test_cpu_traffic();
		logic [31:0] r;
		logic [7:0]  data;
		int          idx;
		for (int i = 0; i < 48; i++) begin
			r = next_rand();
			if (r[0]) begin
				cpu_write(r[23:8], r[31:24]);
			end else begin
				idx = int'(r[15:4]) % written_q.size();
				cpu_read(written_q[idx], data);
				check_byte("cpu read", model_mem[written_q[idx]], data);
			end
		end
		finish_test("cpu traffic");
	endtask

	task automatic test_save_load();
		sd_req_t    exp;
		logic [7:0] data;
		img_size = 32'(2 * SECTOR_BYTES);
		img_mounted = 1'b1;
		@(negedge clk);
		check_level("bk_ena after mount", 1'b1, bk_ena);
		bk_load = 1'b1;
		for (int s = 0; s < 2; s++) begin
			wait_sd_request(50);
			exp = '{lba: LBA_W'(s), rd: 1'b1, wr: 1'b0};
			check_sd("load sector request", exp, sd);
			sd_ack = 1'b1;
			repeat (2) @(negedge clk);
			for (int i = 0; i < SECTOR_BYTES; i++) begin
				data = 8'(next_rand());
				sector_img[s*SECTOR_BYTES+i] = data;
				model_mem[SAVE_BASE + 16'(s*SECTOR_BYTES+i)] = data;
				sd_buff_dout = data;
				sd_buff_wr = 1'b1;
				@(negedge clk);
				sd_buff_wr = 1'b0;
				repeat (7) @(negedge clk);   // Host strobe spacing
			end
			sd_ack = 1'b0;
			@(negedge clk);
		end
		bk_load = 1'b0;
		repeat (4) @(negedge clk);
		check_level("no request after last sector", 1'b0, sd.rd || sd.wr);
		for (int i = 0; i < 2*SECTOR_BYTES; i++) begin
			cpu_read(SAVE_BASE + 16'(i), data);
			check_byte("save window readback", sector_img[i], data);
		end
		finish_test("save load");
	endtask

	task automatic test_save_write();
		logic [31:0] r;
		sd_req_t     exp;
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			cpu_write(SAVE_BASE + 16'(r[9:0]), r[23:16]);
		end
		bk_save = 1'b1;
		for (int s = 0; s < 2; s++) begin
			wait_sd_request(50);
			exp = '{lba: LBA_W'(s), rd: 1'b0, wr: 1'b1};
			check_sd("save sector request", exp, sd);
			sd_ack = 1'b1;
			repeat (2) @(negedge clk);
			for (int i = 0; i < SECTOR_BYTES; i++) begin
				sd_buff_rd = 1'b1;
				@(negedge clk);
				sd_buff_rd = 1'b0;
				repeat (7) @(negedge clk);
				check_byte("saved byte", model_mem[SAVE_BASE + 16'(s*SECTOR_BYTES+i)],
					sd_buff_din);
			end
			sd_ack = 1'b0;
			@(negedge clk);
		end
		bk_save = 1'b0;
		finish_test("save write");
	endtask

	initial begin
		rng_state = 32'h15a5;
		reset_nes = 1'b1;
		cpu = '0;
		joy_a = '0;
		joy_b = '0;
		joy_swap = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		downloading = 1'b0;
		loader_busy = 1'b0;
		loader_done = 1'b0;
		loader_fail = 1'b0;
		loader_flags = '0;
		loader_wr = '0;
		img_mounted = 1'b0;
		img_size = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		sd_ack = 1'b0;
		sd_buff_wr = 1'b0;
		sd_buff_rd = 1'b0;
		sd_buff_dout = 8'h00;
		check_count = 0;
		error_count = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);
		test_joypads();
		test_console_reset();
		test_loader();
		test_cpu_traffic();
		test_save_load();
		test_save_write();
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+tb
src/nes_host_pkg.sv
src/joypad_port.sv
src/boot_reset.sv
src/loader_capture.sv
src/save_backup.sv
src/cart_mem_arbiter.sv
src/nes_host_top.sv
tb/tb_nes_host.sv

/* run_sim.sh */
#!/bin/sh
# Build the NES host testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_nes_host -o tb_nes_host \
	&& ./obj_dir/tb_nes_host > sim.log 2>&1 \
	|| echo "build or run error" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
